//--- bench/rob_tb.sv
// testbench for the reorder buffer, standing in for dispatch, cdb and register file
// random traffic from a fixed seed, checked against a queue model in program order

`default_nettype none

module rob_tb
    import rob_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH       = ROB_DEPTH_DEFAULT;
    localparam int TAG_W       = $clog2(DEPTH);
    localparam int DRAIN_LIMIT = 200;

    // one model entry per dispatched instruction
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        reg_addr_t        rd;
        pc_t              pc;
        inst_type_t       kind;
        logic             complete;
        xlen_t            data;
    } entry_t;

    logic             clk;
    logic             rst;
    logic             disp_valid;
    reg_addr_t        disp_rd;
    pc_t              disp_pc;
    inst_type_t       disp_type;
    logic [TAG_W-1:0] alloc_tag;
    logic             full;
    logic             empty;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    xlen_t            cdb_data;
    logic [TAG_W-1:0] rs1_tag;
    logic [TAG_W-1:0] rs2_tag;
    logic             rs1_ready;
    logic             rs2_ready;
    xlen_t            rs1_data;
    xlen_t            rs2_data;
    logic             retire_valid;
    reg_addr_t        retire_rd;
    xlen_t            retire_data;
    pc_t              retire_pc;
    inst_type_t       retire_type;
    logic             retire_wr_en;

    // model state, oldest instruction at the front
    entry_t model_q[$];
    int     next_tag;
    pc_t    next_pc;
    integer seed;
    int     err_cnt;
    int     chk_cnt;
    logic   timed_out;

    rob_top #(
        .P_ROB_DEPTH (DEPTH)
    ) UUT (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_disp_valid   (disp_valid),
        .i_disp_rd      (disp_rd),
        .i_disp_pc      (disp_pc),
        .i_disp_type    (disp_type),
        .o_alloc_tag    (alloc_tag),
        .o_full         (full),
        .o_empty        (empty),
        .i_cdb_valid    (cdb_valid),
        .i_cdb_tag      (cdb_tag),
        .i_cdb_data     (cdb_data),
        .i_rs1_tag      (rs1_tag),
        .i_rs2_tag      (rs2_tag),
        .o_rs1_ready    (rs1_ready),
        .o_rs2_ready    (rs2_ready),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data),
        .o_retire_valid (retire_valid),
        .o_retire_rd    (retire_rd),
        .o_retire_data  (retire_data),
        .o_retire_pc    (retire_pc),
        .o_retire_type  (retire_type),
        .o_retire_wr_en (retire_wr_en)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_flags(input string what, input logic exp_full, input logic exp_empty);
        chk_cnt++;
        if (full !== exp_full || empty !== exp_empty) begin
            err_cnt++;
            $display("Mismatch at %0t: %s full=%b empty=%b, expected full=%b empty=%b",
                     $time, what, full, empty, exp_full, exp_empty);
        end
    endtask

    task automatic check_tag(input string what, input logic [TAG_W-1:0] exp_tag);
        chk_cnt++;
        if (alloc_tag !== exp_tag) begin
            err_cnt++;
            $display("Mismatch at %0t: %s tag=%0d, expected %0d", $time, what, alloc_tag, exp_tag);
        end
    endtask

    // data only matters once the entry is ready
    task automatic check_lookup(input string what, input logic got_ready, input xlen_t got_data,
                                input logic exp_ready, input xlen_t exp_data);
        chk_cnt++;
        if (got_ready !== exp_ready || (exp_ready && got_data !== exp_data)) begin
            err_cnt++;
            $display("Mismatch at %0t: %s ready=%b data=%h, expected ready=%b data=%h",
                     $time, what, got_ready, got_data, exp_ready, exp_data);
        end
    endtask

    task automatic check_retire(input reg_addr_t exp_rd, input xlen_t exp_data,
                                input pc_t exp_pc, input inst_type_t exp_type);
        logic exp_wr_en;
        // only alu and load write rd
        case (exp_type)
            INST_ALU, INST_LOAD: exp_wr_en = 1'b1;
            default:             exp_wr_en = 1'b0;
        endcase
        chk_cnt++;
        if (retire_rd !== exp_rd || retire_data !== exp_data || retire_pc !== exp_pc
            || retire_type !== exp_type || retire_wr_en !== exp_wr_en) begin
            err_cnt++;
            $display({"Mismatch at %0t: retire pc=%h rd=%0d data=%h type=%0d wr=%b,",
                      " expected %h %0d %h %0d %b"},
                     $time, retire_pc, retire_rd, retire_data, retire_type, retire_wr_en,
                     exp_pc, exp_rd, exp_data, exp_type, exp_wr_en);
        end
    endtask

    // every retirement must match the oldest model entry
    task automatic watch_retire;
        entry_t e;
        if (retire_valid === 1'b1) begin
            if (model_q.size() == 0) begin
                err_cnt++;
                $display("Error at %0t: retirement with no instruction outstanding", $time);
            end else begin
                e = model_q.pop_front();
                if (!e.complete) begin
                    err_cnt++;
                    $display("Error at %0t: pc %h retired before its result arrived", $time, e.pc);
                end
                check_retire(e.rd, e.data, e.pc, e.kind);
            end
        end
    endtask

    // outputs are stable at the falling edge
    task automatic sample_cycle;
        @(negedge clk);
        watch_retire();
    endtask

    // strobes drop unless the caller raises them again
    task automatic drive_edge;
        @(posedge clk);
        disp_valid <= 1'b0;
        cdb_valid  <= 1'b0;
    endtask

    function automatic inst_type_t random_kind();
        return inst_type_t'(2'($random(seed)));
    endfunction

    // picks a random incomplete entry other than skip or returns -1 if none
    function automatic int pick_pending(input int skip);
        int cand[$];
        int r;
        int i;
        for (i = 0; i < model_q.size(); i++) begin
            if (!model_q[i].complete && i != skip) begin
                cand.push_back(i);
            end
        end
        if (cand.size() == 0) begin
            return -1;
        end
        r = $random(seed) & 32'h7fff_ffff;
        return cand[r % cand.size()];
    endfunction

    task automatic issue_dispatch(input inst_type_t kind);
        entry_t e;
        e.tag      = TAG_W'(next_tag);
        e.rd       = reg_addr_t'($random(seed));
        e.pc       = next_pc;
        e.kind     = kind;
        e.complete = 1'b0;
        e.data     = '0;
        // tags come out in circular order
        next_tag   = (next_tag + 1) % DEPTH;
        next_pc    = next_pc + 32'd4;
        model_q.push_back(e);
        disp_valid <= 1'b1;
        disp_rd    <= e.rd;
        disp_pc    <= e.pc;
        disp_type  <= e.kind;
    endtask

    task automatic issue_cdb(input int idx);
        entry_t e;
        e          = model_q[idx];
        e.complete = 1'b1;
        e.data     = $random(seed);
        model_q[idx] = e;
        cdb_valid <= 1'b1;
        cdb_tag   <= e.tag;
        cdb_data  <= e.data;
    endtask

    // one cdb strobe per cycle until nothing is pending
    task automatic complete_all;
        int idx;
        int n;
        for (n = 0; n < DRAIN_LIMIT; n++) begin
            sample_cycle();
            idx = pick_pending(-1);
            drive_edge();
            if (idx < 0) begin
                break;
            end
            issue_cdb(idx);
        end
    endtask

    // waits until every model entry has been seen retiring
    task automatic wait_drain(input string name);
        int   n;
        logic done;
        done = 1'b0;
        for (n = 0; n < DRAIN_LIMIT && !done; n++) begin
            sample_cycle();
            if (model_q.size() == 0) begin
                done = 1'b1;
            end else begin
                drive_edge();
            end
        end
        if (!done) begin
            timed_out = 1'b1;
            $display("Timeout: ROB did not drain within %0d cycles in test %s", DRAIN_LIMIT, name);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("test %-10s %s, %0d errors", name,
                 (err_cnt == errs_before) ? "ok" : "failed", err_cnt - errs_before);
    endtask

    task automatic verify_reset;
        int errs;
        int n;
        errs = err_cnt;
        sample_cycle();
        check_flags("after reset", 1'b0, 1'b1);
        check_tag("after reset", '0);
        for (n = 0; n < 4; n++) begin
            sample_cycle();
            chk_cnt++;
            if (retire_valid !== 1'b0) begin
                err_cnt++;
                $display("Mismatch at %0t: retire strobe high while ROB is empty after reset",
                         $time);
            end
        end
        end_test("reset", errs);
    endtask

    // fill without completing so full rises only at DEPTH entries
    task automatic fill_to_full;
        int errs;
        int n;
        errs = err_cnt;
        for (n = 0; n < DEPTH; n++) begin
            sample_cycle();
            check_tag("dispatch tag", TAG_W'(next_tag));
            check_flags("filling", model_q.size() == DEPTH, model_q.size() == 0);
            drive_edge();
            issue_dispatch(random_kind());
            sample_cycle();
            drive_edge();
        end
        sample_cycle();
        check_flags("filled", 1'b1, 1'b0);
        end_test("tags", errs);
    endtask

    // the completed tag alternates between the rs1 and rs2 ports
    task automatic probe_lookups;
        int               errs;
        int               n;
        int               idx;
        int               other;
        logic             use_rs2;
        logic [TAG_W-1:0] hit_tag;
        logic [TAG_W-1:0] wait_tag;
        xlen_t            hit_data;
        errs = err_cnt;
        for (n = 0; n < 3; n++) begin
            sample_cycle();
            idx   = pick_pending(-1);
            other = pick_pending(idx);
            if (idx < 0 || other < 0) begin
                break;
            end
            use_rs2 = (n % 2) != 0;
            drive_edge();
            issue_cdb(idx);
            hit_tag  = model_q[idx].tag;
            hit_data = model_q[idx].data;
            wait_tag = model_q[other].tag;
            if (use_rs2) begin
                rs1_tag <= wait_tag;
                rs2_tag <= hit_tag;
            end else begin
                rs1_tag <= hit_tag;
                rs2_tag <= wait_tag;
            end
            // no bypass so still pending before the cdb edge
            sample_cycle();
            if (use_rs2) begin
                check_lookup("rs2 before cdb edge", rs2_ready, rs2_data, 1'b0, '0);
            end else begin
                check_lookup("rs1 before cdb edge", rs1_ready, rs1_data, 1'b0, '0);
            end
            drive_edge();
            sample_cycle();
            if (use_rs2) begin
                check_lookup("rs2 after cdb edge", rs2_ready, rs2_data, 1'b1, hit_data);
                check_lookup("rs1 pending", rs1_ready, rs1_data, 1'b0, '0);
            end else begin
                check_lookup("rs1 after cdb edge", rs1_ready, rs1_data, 1'b1, hit_data);
                check_lookup("rs2 pending", rs2_ready, rs2_data, 1'b0, '0);
            end
        end
        end_test("lookup", errs);
    endtask

    // completions in random order while retirement keeps dispatch order
    task automatic drain_in_order;
        int errs;
        errs = err_cnt;
        complete_all();
        wait_drain("order");
        check_flags("order drained", 1'b0, 1'b1);
        end_test("order", errs);
    endtask

    task automatic sweep_types;
        int errs;
        int n;
        errs = err_cnt;
        for (n = 0; n < DEPTH; n++) begin
            sample_cycle();
            drive_edge();
            issue_dispatch(inst_type_t'(2'(n)));
        end
        complete_all();
        wait_drain("wr_en");
        check_flags("wr_en drained", 1'b0, 1'b1);
        end_test("wr_en", errs);
    endtask

    task automatic mixed_traffic;
        int   errs;
        int   cyc;
        int   idx;
        logic want_disp;
        errs = err_cnt;
        for (cyc = 0; cyc < 400; cyc++) begin
            sample_cycle();
            // model count never undercounts the ROB, so this keeps o_full honest
            want_disp = (($random(seed) & 3) != 0) && full !== 1'b1 && model_q.size() < DEPTH;
            idx = -1;
            if (($random(seed) & 1) != 0) begin
                idx = pick_pending(-1);
            end
            drive_edge();
            if (idx >= 0) begin
                issue_cdb(idx);
            end
            if (want_disp) begin
                issue_dispatch(random_kind());
            end
        end
        complete_all();
        wait_drain("traffic");
        check_flags("traffic drained", 1'b0, 1'b1);
        end_test("traffic", errs);
    endtask

    initial begin
        seed       = 4;
        err_cnt    = 0;
        chk_cnt    = 0;
        timed_out  = 1'b0;
        next_tag   = 0;
        next_pc    = 32'h0000_1000;
        rst        = 1'b1;
        disp_valid = 1'b0;
        disp_rd    = '0;
        disp_pc    = '0;
        disp_type  = INST_ALU;
        cdb_valid  = 1'b0;
        cdb_tag    = '0;
        cdb_data   = '0;
        rs1_tag    = '0;
        rs2_tag    = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        verify_reset();
        fill_to_full();
        probe_lookups();
        drain_in_order();
        if (!timed_out) begin
            sweep_types();
        end
        if (!timed_out) begin
            mixed_traffic();
        end

        $display("summary: %0d checks, %0d errors%s", chk_cnt, err_cnt,
                 timed_out ? ", timed out" : "");
        if (err_cnt == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : rob_tb

`default_nettype wire

//--- build.f
src/rob_pkg.sv
src/rob_tag_alloc.sv
src/rob_entry_file.sv
src/rob_retire.sv
src/rob_top.sv
bench/rob_tb.sv

//--- run_sim.sh
#!/bin/sh
# compiles the ROB testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rob_tb --Mdir "$OBJ" -o rob_sim -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/rob_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1

//--- src/rob_entry_file.sv
// per-tag storage of the reorder buffer entries
// written at dispatch, completed from the cdb, read by lookup and retire

`default_nettype none

module rob_entry_file
    import rob_pkg::*;
#(
    parameter int P_ROB_DEPTH = ROB_DEPTH_DEFAULT
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    // dispatch write
    input  wire logic                           i_wr_en,
    input  wire logic      [$clog2(P_ROB_DEPTH)-1:0] i_wr_tag,
    input  wire reg_addr_t                      i_wr_rd,
    input  wire pc_t                            i_wr_pc,
    input  wire inst_type_t                     i_wr_type,
    // cdb update
    input  wire logic                           i_cdb_valid,
    input  wire logic      [$clog2(P_ROB_DEPTH)-1:0] i_cdb_tag,
    input  wire xlen_t                          i_cdb_data,
    // retire clear
    input  wire logic                           i_clr_en,
    input  wire logic      [$clog2(P_ROB_DEPTH)-1:0] i_clr_tag,
    // operand lookups for dispatch
    input  wire logic      [$clog2(P_ROB_DEPTH)-1:0] i_rs1_tag,
    input  wire logic      [$clog2(P_ROB_DEPTH)-1:0] i_rs2_tag,
    output logic                                o_rs1_ready,
    output logic                                o_rs2_ready,
    output xlen_t                               o_rs1_data,
    output xlen_t                               o_rs2_data,
    // oldest entry, handed to retire
    input  wire logic      [$clog2(P_ROB_DEPTH)-1:0] i_head_tag,
    output logic                                o_head_done,
    output reg_addr_t                           o_head_rd,
    output xlen_t                               o_head_data,
    output pc_t                                 o_head_pc,
    output inst_type_t                          o_head_type
);

    // entry control bits
    logic [P_ROB_DEPTH-1:0] valid_q;
    logic [P_ROB_DEPTH-1:0] done_q;

    // entry payload
    reg_addr_t  rd_q   [P_ROB_DEPTH];
    pc_t        pc_q   [P_ROB_DEPTH];
    inst_type_t type_q [P_ROB_DEPTH];
    xlen_t      data_q [P_ROB_DEPTH];

    // cdb only lands on a live entry
    logic cdb_hit;

    assign cdb_hit = i_cdb_valid & valid_q[i_cdb_tag];

    // control state
    // write and clear never share a tag: that needs head == tail,
    // which is empty (no clear) or full (no write)
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (i_wr_en) begin
                valid_q[i_wr_tag] <= 1'b1;
                done_q[i_wr_tag]  <= 1'b0;
            end
            if (cdb_hit) begin
                done_q[i_cdb_tag] <= 1'b1;
            end
            if (i_clr_en) begin
                valid_q[i_clr_tag] <= 1'b0;
                done_q[i_clr_tag]  <= 1'b0;
            end
        end
    end

    // payload fields
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            rd_q[i_wr_tag]   <= i_wr_rd;
            pc_q[i_wr_tag]   <= i_wr_pc;
            type_q[i_wr_tag] <= i_wr_type;
        end
        if (cdb_hit) begin
            data_q[i_cdb_tag] <= i_cdb_data;
        end
    end

    // lookups read stored state only
    // a cdb result shows up the cycle after its edge
    assign o_rs1_ready = valid_q[i_rs1_tag] & done_q[i_rs1_tag];
    assign o_rs2_ready = valid_q[i_rs2_tag] & done_q[i_rs2_tag];
    assign o_rs1_data  = data_q[i_rs1_tag];
    assign o_rs2_data  = data_q[i_rs2_tag];

    // head entry view
    assign o_head_done = valid_q[i_head_tag] & done_q[i_head_tag];
    assign o_head_rd   = rd_q[i_head_tag];
    assign o_head_data = data_q[i_head_tag];
    assign o_head_pc   = pc_q[i_head_tag];
    assign o_head_type = type_q[i_head_tag];

    // tail allocation must only ever hand out free slots
    a_wr_to_free_entry : assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_wr_en |-> !valid_q[i_wr_tag]
    ) else $error("rob_entry_file: dispatch write to a live entry");

endmodule : rob_entry_file

`default_nettype wire

//--- src/rob_pkg.sv
// shared widths and instruction type encoding for the reorder buffer
// imported by every ROB module that carries data, addresses or types

`default_nettype none

package rob_pkg;

    // default entry count, a power of two so the pointers wrap on their own
    localparam int ROB_DEPTH_DEFAULT = 8;

    // result word broadcast on the cdb
    typedef logic [31:0] xlen_t;

    // instruction address
    typedef logic [31:0] pc_t;

    // architectural register number, x0..x31
    typedef logic [4:0] reg_addr_t;

    // instruction class as seen by the ROB
    // only alu and load results go to the register file
    typedef enum logic [1:0] {
        INST_ALU    = 2'b00,
        INST_LOAD   = 2'b01,
        INST_STORE  = 2'b10,
        INST_BRANCH = 2'b11
    } inst_type_t;

endpackage : rob_pkg

`default_nettype wire

//--- src/rob_retire.sv
// in-order retirement of the head entry, one per cycle
// frees the head when it is complete and registers the retire bus

`default_nettype none

module rob_retire
    import rob_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    // head entry from the entry file
    input  wire logic       i_head_done,
    input  wire reg_addr_t  i_head_rd,
    input  wire xlen_t      i_head_data,
    input  wire pc_t        i_head_pc,
    input  wire inst_type_t i_head_type,
    // frees the head entry and advances the head pointer
    output logic            o_release,
    // retire bus toward the register file
    output logic            o_retire_valid,
    output reg_addr_t       o_retire_rd,
    output xlen_t           o_retire_data,
    output pc_t             o_retire_pc,
    output inst_type_t      o_retire_type,
    output logic            o_retire_wr_en
);

    // register write only for instructions that produce rd
    logic head_writes_rd;

    // retire as soon as the head has its result
    assign o_release = i_head_done;

    // stores and branches leave the register file alone
    always_comb begin
        case (i_head_type)
            INST_ALU:  head_writes_rd = 1'b1;
            INST_LOAD: head_writes_rd = 1'b1;
            default:   head_writes_rd = 1'b0;
        endcase
    end

    // strobe and write enable
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_retire_valid <= 1'b0;
            o_retire_wr_en <= 1'b0;
        end else begin
            o_retire_valid <= o_release;
            o_retire_wr_en <= o_release & head_writes_rd;
        end
    end

    // payload captured on release and held otherwise
    always_ff @(posedge i_clk) begin
        if (o_release) begin
            o_retire_rd   <= i_head_rd;
            o_retire_data <= i_head_data;
            o_retire_pc   <= i_head_pc;
            o_retire_type <= i_head_type;
        end
    end

endmodule : rob_retire

`default_nettype wire

//--- src/rob_tag_alloc.sv
// circular head/tail pointers of the reorder buffer
// tail hands out the dispatch tag, head points at the oldest entry

`default_nettype none

module rob_tag_alloc
    import rob_pkg::*;
#(
    parameter int P_ROB_DEPTH = ROB_DEPTH_DEFAULT
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    // dispatch strobe, one tag per cycle
    input  wire logic                           i_alloc,
    // retire strobe, frees the head entry
    input  wire logic                           i_release,
    output logic      [$clog2(P_ROB_DEPTH)-1:0] o_tail_tag,
    output logic      [$clog2(P_ROB_DEPTH)-1:0] o_head_tag,
    output logic                                o_full,
    output logic                                o_empty
);

    localparam int LP_TAG_W = $clog2(P_ROB_DEPTH);

    // one extra wrap bit on each pointer
    // equal pointers mean empty, wrap bits apart mean full
    logic [LP_TAG_W:0] head_q;
    logic [LP_TAG_W:0] tail_q;

    logic wrap_diff;
    logic idx_same;

    // tail pointer
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            tail_q <= '0;
        end else if (i_alloc) begin
            tail_q <= tail_q + 1'b1;
        end
    end

    // head pointer
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            head_q <= '0;
        end else if (i_release) begin
            head_q <= head_q + 1'b1;
        end
    end

    assign wrap_diff = head_q[LP_TAG_W] ^ tail_q[LP_TAG_W];
    assign idx_same  = (head_q[LP_TAG_W-1:0] == tail_q[LP_TAG_W-1:0]);

    // flags straight from registered pointers, no input path
    assign o_full  = idx_same & wrap_diff;
    assign o_empty = idx_same & ~wrap_diff;

    // low bits are the entry tags
    assign o_tail_tag = tail_q[LP_TAG_W-1:0];
    assign o_head_tag = head_q[LP_TAG_W-1:0];

    // dispatcher has to hold off while full, else the tail laps the head
    a_no_alloc_when_full : assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_alloc |-> !o_full
    ) else $error("rob_tag_alloc: dispatch while ROB full");

    // retire only fires on a valid head, so an empty ROB never releases
    a_no_release_when_empty : assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_release |-> !o_empty
    ) else $error("rob_tag_alloc: release while ROB empty");

    // the pointer wrap relies on a power-of-two depth
    if ((1 << LP_TAG_W) != P_ROB_DEPTH) begin : g_depth_check
        $error("rob_tag_alloc: P_ROB_DEPTH must be a power of two");
    end

endmodule : rob_tag_alloc

`default_nettype wire

//--- src/rob_top.sv
// reorder buffer top: allocation, entry storage and retirement
// dispatch, cdb, lookup and retire ports face the rest of the core

`default_nettype none

module rob_top
    import rob_pkg::*;
#(
    parameter int P_ROB_DEPTH = ROB_DEPTH_DEFAULT
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    // dispatch
    input  wire logic                           i_disp_valid,
    input  wire reg_addr_t                      i_disp_rd,
    input  wire pc_t                            i_disp_pc,
    input  wire inst_type_t                     i_disp_type,
    output logic      [$clog2(P_ROB_DEPTH)-1:0] o_alloc_tag,
    output logic                                o_full,
    output logic                                o_empty,
    // cdb
    input  wire logic                           i_cdb_valid,
    input  wire logic      [$clog2(P_ROB_DEPTH)-1:0] i_cdb_tag,
    input  wire xlen_t                          i_cdb_data,
    // operand lookups
    input  wire logic      [$clog2(P_ROB_DEPTH)-1:0] i_rs1_tag,
    input  wire logic      [$clog2(P_ROB_DEPTH)-1:0] i_rs2_tag,
    output logic                                o_rs1_ready,
    output logic                                o_rs2_ready,
    output xlen_t                               o_rs1_data,
    output xlen_t                               o_rs2_data,
    // retire
    output logic                                o_retire_valid,
    output reg_addr_t                           o_retire_rd,
    output xlen_t                               o_retire_data,
    output pc_t                                 o_retire_pc,
    output inst_type_t                          o_retire_type,
    output logic                                o_retire_wr_en
);

    localparam int LP_TAG_W = $clog2(P_ROB_DEPTH);

    // head side
    logic [LP_TAG_W-1:0] head_tag;
    logic                head_release;
    logic                head_done;
    reg_addr_t           head_rd;
    xlen_t               head_data;
    pc_t                 head_pc;
    inst_type_t          head_type;

    // pointers with the tail tag doubling as the dispatch tag
    rob_tag_alloc #(
        .P_ROB_DEPTH (P_ROB_DEPTH)
    ) u_tag_alloc (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_alloc    (i_disp_valid),
        .i_release  (head_release),
        .o_tail_tag (o_alloc_tag),
        .o_head_tag (head_tag),
        .o_full     (o_full),
        .o_empty    (o_empty)
    );

    // entries are written at the tail and cleared at the head
    rob_entry_file #(
        .P_ROB_DEPTH (P_ROB_DEPTH)
    ) u_entry_file (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_wr_en     (i_disp_valid),
        .i_wr_tag    (o_alloc_tag),
        .i_wr_rd     (i_disp_rd),
        .i_wr_pc     (i_disp_pc),
        .i_wr_type   (i_disp_type),
        .i_cdb_valid (i_cdb_valid),
        .i_cdb_tag   (i_cdb_tag),
        .i_cdb_data  (i_cdb_data),
        .i_clr_en    (head_release),
        .i_clr_tag   (head_tag),
        .i_rs1_tag   (i_rs1_tag),
        .i_rs2_tag   (i_rs2_tag),
        .o_rs1_ready (o_rs1_ready),
        .o_rs2_ready (o_rs2_ready),
        .o_rs1_data  (o_rs1_data),
        .o_rs2_data  (o_rs2_data),
        .i_head_tag  (head_tag),
        .o_head_done (head_done),
        .o_head_rd   (head_rd),
        .o_head_data (head_data),
        .o_head_pc   (head_pc),
        .o_head_type (head_type)
    );

    // release frees the entry and moves the head
    rob_retire u_retire (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_head_done    (head_done),
        .i_head_rd      (head_rd),
        .i_head_data    (head_data),
        .i_head_pc      (head_pc),
        .i_head_type    (head_type),
        .o_release      (head_release),
        .o_retire_valid (o_retire_valid),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data),
        .o_retire_pc    (o_retire_pc),
        .o_retire_type  (o_retire_type),
        .o_retire_wr_en (o_retire_wr_en)
    );

endmodule : rob_top

`default_nettype wire
